// ==== verilog/slice_cfg.svh ====
/*
 * Build-time sizing of the SIMD FP slice
 * The datapath is fixed at 32 bits; FP64 is not supported
 * SLICE_PIPE_REGS of 0 makes the slice purely combinational
 */

`ifndef SLICE_CFG_SVH
`define SLICE_CFG_SVH

// Datapath width in bits
`define SLICE_WIDTH 32

// Lanes of the narrowest format (FP8) in one word
`define SLICE_NUM_LANES 4

`define SLICE_PIPE_REGS 2   // Default register stages
`define SLICE_TAG_WIDTH 4   // User tag carried with each operation

`endif

// ==== verilog/slice_pkg.sv ====
/*
 * Formats, operations, status flags and the payload that travels through
 * the slice pipeline. FP8 is the 1-5-2 layout. Format code 3 is not
 * defined and is treated as FP32 by the width helpers.
 */

`include "slice_cfg.svh"

package slice_pkg;

  typedef logic [`SLICE_WIDTH-1:0] word_t;

  typedef enum logic [1:0] {
    FP32 = 2'd0,
    FP16 = 2'd1,
    FP8  = 2'd2
  } fp_format_e;

  typedef enum logic [1:0] {
    SGNJ  = 2'd0,
    SGNJN = 2'd1,
    SGNJX = 2'd2,
    FEQ   = 2'd3
  } operation_e;

  // IEEE exception flags, only nv is produced here
  typedef struct packed {
    logic nv;  // Invalid operation
    logic dz;  // Divide by zero
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } status_t;

  typedef logic [`SLICE_TAG_WIDTH-1:0] tag_t;

  typedef word_t [`SLICE_NUM_LANES-1:0] lane_res_t;  // One field per lane

  // Facts the result packer needs at the pipeline end
  typedef struct packed {
    fp_format_e fmt;
    operation_e op;
    logic       vectorial;
    tag_t       tag;
  } aux_t;

  typedef struct packed {
    lane_res_t                  res;
    logic [`SLICE_NUM_LANES-1:0] lane_nv;
    aux_t                       aux;
  } slice_payload_t;

  // ------------------------------------------------------------------------
  // Format helpers
  // ------------------------------------------------------------------------
  function automatic int unsigned fp_width(fp_format_e fmt);
    case (fmt)
      FP16:    return 16;
      FP8:     return 8;
      default: return 32;
    endcase
  endfunction

  function automatic int unsigned num_lanes(fp_format_e fmt);
    return `SLICE_WIDTH / fp_width(fmt);
  endfunction

  // Ones over the low fp_width bits
  function automatic word_t lane_mask(fp_format_e fmt);
    return {`SLICE_WIDTH{1'b1}} >> (`SLICE_WIDTH - fp_width(fmt));
  endfunction

endpackage

// ==== verilog/lane_ops.sv ====
/*
 * Per-lane sign injection and quiet equality, purely combinational
 * Operands are not checked for NaN boxing; upper input bits are ignored
 * Lane fields come out right aligned in their word_t slot
 */

`timescale 1ns/100ps

`include "slice_cfg.svh"

module lane_ops (
  input  slice_pkg::word_t          operand_a_i,
  input  slice_pkg::word_t          operand_b_i,
  input  slice_pkg::operation_e     op_i,
  input  slice_pkg::fp_format_e     fmt_i,
  input  logic                      vectorial_i,
  input  slice_pkg::tag_t           tag_i,
  output slice_pkg::slice_payload_t payload_o
);

  // Mantissa width of each format
  function automatic int unsigned man_bits(slice_pkg::fp_format_e fmt);
    case (fmt)
      slice_pkg::FP16: return 10;
      slice_pkg::FP8:  return 2;
      default:         return 23;
    endcase
  endfunction

  int unsigned      lane_w;      // Bits per lane
  int unsigned      man_w;       // Mantissa bits per lane
  int unsigned      lanes_avail; // Lanes that fit the format
  slice_pkg::word_t lane_msk;
  slice_pkg::word_t mag_msk;
  slice_pkg::word_t man_msk;
  slice_pkg::word_t exp_msk;

  slice_pkg::lane_res_t         lane_res;
  logic [`SLICE_NUM_LANES-1:0]  lane_nv;

  // ------------------------------------------------------------------------
  // Field masks for the selected format
  // ------------------------------------------------------------------------
  always_comb begin : field_masks
    lane_w      = slice_pkg::fp_width(fmt_i);
    man_w       = man_bits(fmt_i);
    lanes_avail = slice_pkg::num_lanes(fmt_i);
    lane_msk    = slice_pkg::lane_mask(fmt_i);
    mag_msk     = lane_msk >> 1;                           // All but the sign
    man_msk     = (slice_pkg::word_t'(1) << man_w) - 1'b1;
    exp_msk     = mag_msk & ~man_msk;
  end

  // ------------------------------------------------------------------------
  // Lanes
  // ------------------------------------------------------------------------
  for (genvar l = 0; l < `SLICE_NUM_LANES; l++) begin : gen_lanes
    slice_pkg::word_t a_fld;
    slice_pkg::word_t b_fld;
    logic             a_sign, b_sign, new_sign;
    logic             a_nan, b_nan, a_snan, b_snan;
    logic             both_zero, equal, active;

    // Right align this lane of each operand
    assign a_fld = (operand_a_i >> (l * lane_w)) & lane_msk;
    assign b_fld = (operand_b_i >> (l * lane_w)) & lane_msk;

    assign a_sign = a_fld[lane_w-1];
    assign b_sign = b_fld[lane_w-1];

    // Exponent all ones with a nonzero mantissa
    assign a_nan  = ((a_fld & exp_msk) == exp_msk) && ((a_fld & man_msk) != '0);
    assign b_nan  = ((b_fld & exp_msk) == exp_msk) && ((b_fld & man_msk) != '0);
    assign a_snan = a_nan && !a_fld[man_w-1];  // Quiet bit is the mantissa MSB
    assign b_snan = b_nan && !b_fld[man_w-1];

    assign both_zero = ((a_fld & mag_msk) == '0) && ((b_fld & mag_msk) == '0);
    assign equal     = !a_nan && !b_nan && ((a_fld == b_fld) || both_zero);

    always_comb begin : sign_select
      case (op_i)
        slice_pkg::SGNJ:  new_sign = b_sign;
        slice_pkg::SGNJN: new_sign = ~b_sign;
        slice_pkg::SGNJX: new_sign = a_sign ^ b_sign;
        default:          new_sign = a_sign;
      endcase
    end

    // Scalar ops only touch lane 0
    assign active = (l < lanes_avail) && ((l == 0) || vectorial_i);

    always_comb begin : lane_result
      lane_res[l] = '0;
      lane_nv[l]  = 1'b0;
      if (active) begin
        if (op_i == slice_pkg::FEQ) begin
          lane_res[l] = slice_pkg::word_t'(equal);
          lane_nv[l]  = a_snan || b_snan;  // Signaling NaN is invalid for quiet compare
        end else begin
          lane_res[l] = (a_fld & mag_msk) | (slice_pkg::word_t'(new_sign) << (lane_w - 1));
        end
      end
    end
  end

  assign payload_o.res           = lane_res;
  assign payload_o.lane_nv       = lane_nv;
  assign payload_o.aux.fmt       = fmt_i;
  assign payload_o.aux.op        = op_i;
  assign payload_o.aux.vectorial = vectorial_i;
  assign payload_o.aux.tag       = tag_i;

endmodule

// ==== verilog/slice_pipe.sv ====
/*
 * Elastic valid/ready register pipeline for the slice payload
 * NumPipeRegs of 0 gives a combinational pass with no storage
 * flush_i drops every item in flight on the next edge
 */

`timescale 1ns/100ps

module slice_pipe #(
  parameter int unsigned NumPipeRegs = 0
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      flush_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  slice_pkg::slice_payload_t payload_i,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output slice_pkg::slice_payload_t payload_o,
  output logic                      busy_o
);

  // Index i holds the item after i register stages
  logic [0:NumPipeRegs]      stage_valid;
  logic [0:NumPipeRegs]      stage_ready;
  slice_pkg::slice_payload_t stage_data [0:NumPipeRegs];

  assign stage_valid[0] = in_valid_i;
  assign stage_data[0]  = payload_i;

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stages
    logic load;

    // Advance when downstream takes it or only a bubble sits there
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];
    assign load           = stage_ready[i] & stage_valid[i];

    always_ff @(posedge clk_i) begin
      if (rst_i || flush_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (load) begin
        stage_data[i+1] <= stage_data[i];  // Holds its item while stalled
      end
    end
  end

  // ------------------------------------------------------------------------
  // Output side
  // ------------------------------------------------------------------------
  assign stage_ready[NumPipeRegs] = out_ready_i;
  assign in_ready_o               = stage_ready[0];
  assign out_valid_o              = stage_valid[NumPipeRegs];
  assign payload_o                = stage_data[NumPipeRegs];

  if (NumPipeRegs > 0) begin : gen_busy_regs
    assign busy_o = |stage_valid[1:NumPipeRegs];
  end else begin : gen_busy_comb
    assign busy_o = stage_valid[0];  // Only the item passing through
  end

endmodule

// ==== verilog/result_pack.sv ====
/*
 * Packs per-lane fields into one result word by the carried format
 * Inactive bits are NaN boxed with ones for sign injection and are
 * zero for FEQ; status is the OR of the lane flags
 */

`timescale 1ns/100ps

`include "slice_cfg.svh"

module result_pack (
  input  slice_pkg::slice_payload_t payload_i,
  output slice_pkg::word_t          result_o,
  output slice_pkg::status_t        status_o,
  output slice_pkg::tag_t           tag_o
);

  slice_pkg::fp_format_e fmt;
  slice_pkg::operation_e op;
  logic                  is_vector;

  assign fmt       = payload_i.aux.fmt;
  assign op        = payload_i.aux.op;
  assign is_vector = payload_i.aux.vectorial;

  // ------------------------------------------------------------------------
  // Lane placement
  // ------------------------------------------------------------------------
  always_comb begin : pack_lanes
    slice_pkg::word_t packed_res;
    slice_pkg::word_t lmask;
    int unsigned      lw;
    int unsigned      nl;

    lw    = slice_pkg::fp_width(fmt);
    nl    = slice_pkg::num_lanes(fmt);
    lmask = slice_pkg::lane_mask(fmt);

    // Fill pattern for unused bits
    packed_res = '1;
    if (op == slice_pkg::FEQ) begin
      packed_res = '0;
    end

    for (int unsigned l = 0; l < `SLICE_NUM_LANES; l++) begin
      if ((l < nl) && ((l == 0) || is_vector)) begin
        packed_res = (packed_res & ~(lmask << (l * lw)))
                   | ((payload_i.res[l] & lmask) << (l * lw));
      end
    end

    result_o = packed_res;
  end

  // ------------------------------------------------------------------------
  // Status and tag
  // ------------------------------------------------------------------------
  always_comb begin : collapse_status
    status_o    = '0;
    status_o.nv = |payload_i.lane_nv;  // Lane flags already masked per lane
  end

  assign tag_o = payload_i.aux.tag;

endmodule

// ==== verilog/multifmt_slice.sv ====
/*
 * Top of the 32-bit multi-format SIMD slice: SGNJ, SGNJN, SGNJX and FEQ
 * FP32 x1, FP16 x2 or FP8 x4; scalar ops use lane 0 only
 * Latency is SLICE_PIPE_REGS cycles with out_ready_i held high
 */

`timescale 1ns/100ps

`include "slice_cfg.svh"

module multifmt_slice (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  flush_i,
  // Operation
  input  slice_pkg::word_t      operand_a_i,
  input  slice_pkg::word_t      operand_b_i,
  input  slice_pkg::operation_e op_i,
  input  slice_pkg::fp_format_e fmt_i,
  input  logic                  vectorial_i,
  input  slice_pkg::tag_t       tag_i,
  // Input handshake
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  // Result
  output slice_pkg::word_t      result_o,
  output slice_pkg::status_t    status_o,
  output slice_pkg::tag_t       tag_o,
  // Output handshake
  input  logic                  out_ready_i,
  output logic                  out_valid_o,
  output logic                  busy_o     // Items in flight
);

  slice_pkg::slice_payload_t lane_payload;  // Producer to pipeline
  slice_pkg::slice_payload_t pipe_payload;  // Pipeline to packer

  // ------------------------------------------------------------------------
  // Lane operations, all lanes in lockstep
  // ------------------------------------------------------------------------
  lane_ops i_lane_ops (
    .operand_a_i ( operand_a_i  ),
    .operand_b_i ( operand_b_i  ),
    .op_i        ( op_i         ),
    .fmt_i       ( fmt_i        ),
    .vectorial_i ( vectorial_i  ),
    .tag_i       ( tag_i        ),
    .payload_o   ( lane_payload )
  );

  slice_pipe #(
    .NumPipeRegs ( `SLICE_PIPE_REGS )
  ) i_slice_pipe (
    .clk_i       ( clk_i        ),
    .rst_i       ( rst_i        ),
    .flush_i     ( flush_i      ),
    .in_valid_i  ( in_valid_i   ),
    .in_ready_o  ( in_ready_o   ),
    .payload_i   ( lane_payload ),
    .out_valid_o ( out_valid_o  ),
    .out_ready_i ( out_ready_i  ),
    .payload_o   ( pipe_payload ),
    .busy_o      ( busy_o       )
  );

  // Boxing and status collapse after the last stage
  result_pack i_result_pack (
    .payload_i ( pipe_payload ),
    .result_o  ( result_o     ),
    .status_o  ( status_o     ),
    .tag_o     ( tag_o        )
  );

endmodule

// ==== test/tb_multifmt_slice.sv ====
/*
 * Testbench for the multi-format SIMD slice, latency taken from SLICE_PIPE_REGS
 * Stimulus is seeded $random, results are checked in order against a model
 * The run stops at the first mismatch
 */

`timescale 1ns/100ps

`include "slice_cfg.svh"

module tb_multifmt_slice;

  localparam int unsigned PIPE       = `SLICE_PIPE_REGS;
  localparam int unsigned CLK_PERIOD = 100;
  localparam int unsigned DRIVE_DLY  = 10;
  localparam int unsigned NUM_OPS    = 136 + PIPE;              // Includes the flushed items
  localparam int unsigned TIMEOUT    = NUM_OPS * (PIPE + 8) + 100;

  typedef struct packed {
    slice_pkg::word_t   res;
    slice_pkg::status_t status;
    slice_pkg::tag_t    tag;
  } expect_t;

  logic                  clk_i, rst_i, flush_i, in_valid_i, out_ready_i, vectorial_i;
  slice_pkg::word_t      operand_a_i, operand_b_i, result_o;
  slice_pkg::operation_e op_i;
  slice_pkg::fp_format_e fmt_i;
  slice_pkg::tag_t       tag_i, tag_o;
  slice_pkg::status_t    status_o;
  logic                  in_ready_o, out_valid_o, busy_o;

  int              seed = 32'hbaf1c8f4;
  int unsigned     cycle_count = 0;
  int unsigned     n_checked = 0;
  logic [1:0]      ready_mode;     // 0 high, 1 low, 2 random
  logic            latency_on;
  slice_pkg::tag_t next_tag;
  expect_t         exp_q[$];
  int unsigned     acc_q[$];       // Acceptance cycle of each queued item

  multifmt_slice uut (
    .clk_i, .rst_i, .flush_i, .operand_a_i, .operand_b_i, .op_i, .fmt_i, .vectorial_i,
    .tag_i, .in_valid_i, .in_ready_o, .result_o, .status_o, .tag_o, .out_ready_i,
    .out_valid_o, .busy_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic int unsigned lane_bits(slice_pkg::fp_format_e fmt);
    return (fmt == slice_pkg::FP16) ? 16 : (fmt == slice_pkg::FP8) ? 8 : 32;
  endfunction

  function automatic logic nan_of(slice_pkg::word_t f, int unsigned w, int unsigned mb);
    slice_pkg::word_t emask;
    emask = ((slice_pkg::word_t'(1) << (w - 1 - mb)) - 1) << mb;
    return ((f & emask) == emask) && ((f & ((slice_pkg::word_t'(1) << mb) - 1)) != '0);
  endfunction

  function automatic expect_t compute_expected(slice_pkg::word_t a, slice_pkg::word_t b,
      slice_pkg::operation_e op, slice_pkg::fp_format_e fmt, logic vec, slice_pkg::tag_t tag);
    expect_t          e;
    int unsigned      w, mb, lanes;
    slice_pkg::word_t lmask, fa, fb, val;
    logic             sr, a_nan, b_nan, zeros;
    w     = lane_bits(fmt);
    mb    = (w == 32) ? 23 : (w == 16) ? 10 : 2;
    lanes = vec ? 32 / w : 1;
    lmask = (w == 32) ? '1 : (slice_pkg::word_t'(1) << w) - 1;
    e.res    = (op == slice_pkg::FEQ) ? '0 : '1;  // Box or zero fill
    e.status = '0;
    e.tag    = tag;
    for (int unsigned l = 0; l < lanes; l++) begin
      fa    = (a >> (l * w)) & lmask;
      fb    = (b >> (l * w)) & lmask;
      a_nan = nan_of(fa, w, mb);
      b_nan = nan_of(fb, w, mb);
      if (op == slice_pkg::FEQ) begin
        zeros = ((fa & (lmask >> 1)) == '0) && ((fb & (lmask >> 1)) == '0);
        val   = slice_pkg::word_t'(!a_nan && !b_nan && ((fa == fb) || zeros));
        if ((a_nan && !fa[mb-1]) || (b_nan && !fb[mb-1])) e.status.nv = 1'b1;
      end else begin
        case (op)
          slice_pkg::SGNJ:  sr = fb[w-1];
          slice_pkg::SGNJN: sr = ~fb[w-1];
          default:          sr = fa[w-1] ^ fb[w-1];
        endcase
        val = (fa & (lmask >> 1)) | (slice_pkg::word_t'(sr) << (w - 1));
      end
      e.res = (e.res & ~(lmask << (l * w))) | (val << (l * w));
    end
    return e;
  endfunction

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic stop_run();
    $display("CHECKS FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_result(slice_pkg::word_t got, slice_pkg::word_t exp);
    if (got !== exp) begin
      $display("[FAIL] result_o: got %h, expected %h", got, exp);
      stop_run();
    end
  endtask

  task automatic check_status(slice_pkg::status_t got, slice_pkg::status_t exp);
    if (got !== exp) begin
      $display("[FAIL] status_o: got %h, expected %h", got, exp);
      stop_run();
    end
  endtask

  task automatic check_tag(slice_pkg::tag_t got, slice_pkg::tag_t exp);
    if (got !== exp) begin
      $display("[FAIL] tag_o: got %h, expected %h", got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      stop_run();
    end
  endtask

  // --------------------------------------------------------------------------
  // Scoreboard, sampled at the falling edge where all signals are settled
  // --------------------------------------------------------------------------
  always @(negedge clk_i) begin : scoreboard
    expect_t          e;
    int unsigned      acc;
    logic             hold_pending;
    slice_pkg::word_t hold_res;
    if (!rst_i) begin
      if (hold_pending) begin            // Stalled output must not move
        check_bit("out_valid_o", out_valid_o, 1'b1);
        check_result(result_o, hold_res);
      end
      hold_pending = out_valid_o && !out_ready_i && !flush_i;
      hold_res     = result_o;
      // Push first so a zero-stage pipe sees its own input
      if (in_valid_i && in_ready_o) begin
        exp_q.push_back(compute_expected(operand_a_i, operand_b_i, op_i, fmt_i,
                                         vectorial_i, tag_i));
        acc_q.push_back(cycle_count);
      end
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Output transfer with no operation pending, tag %h", tag_o);
          stop_run();
        end
        e   = exp_q.pop_front();
        acc = acc_q.pop_front();
        check_result(result_o, e.res);
        check_status(status_o, e.status);
        check_tag(tag_o, e.tag);
        if (latency_on && (cycle_count - acc) != PIPE) begin
          $display("[FAIL] out_valid_o latency: got %0h, expected %0h", cycle_count - acc, PIPE);
          stop_run();
        end
        n_checked++;
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle_count++;
    if (cycle_count >= TIMEOUT) begin
      $display("Run timed out after %0d cycles", cycle_count);
      stop_run();
    end
  end

  // Mode is read at the edge, the value is driven after the delay
  always @(posedge clk_i) begin : ready_driver
    logic [31:0] r;
    logic        next_ready;
    r          = $random(seed);
    next_ready = (ready_mode == 2'd2) ? r[0] : (ready_mode == 2'd0);
    #DRIVE_DLY;
    out_ready_i = next_ready;
  end

  // --------------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------------
  task automatic send_op(input slice_pkg::word_t a, input slice_pkg::word_t b,
      input slice_pkg::operation_e op, input slice_pkg::fp_format_e fmt, input logic vec);
    operand_a_i = a;
    operand_b_i = b;
    op_i        = op;
    fmt_i       = fmt;
    vectorial_i = vec;
    tag_i       = next_tag;
    in_valid_i  = 1'b1;
    @(negedge clk_i);
    while (!in_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #DRIVE_DLY;
    in_valid_i = 1'b0;
    next_tag   = next_tag + 1'b1;
  endtask

  task automatic wait_idle();
    @(negedge clk_i);
    while (busy_o || exp_q.size() != 0) @(negedge clk_i);
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  function automatic slice_pkg::word_t special_value(slice_pkg::fp_format_e fmt,
      logic [2:0] kind, slice_pkg::word_t rnd);
    slice_pkg::word_t sgn, one, qnan, snan;
    case (fmt)
      slice_pkg::FP16: {sgn, one, qnan, snan} = {32'h8000, 32'h3c00, 32'h7e00, 32'h7c01};
      slice_pkg::FP8:  {sgn, one, qnan, snan} = {32'h80, 32'h3c, 32'h7e, 32'h7d};
      default: {sgn, one, qnan, snan} = {32'h80000000, 32'h3f800000, 32'h7fc00000, 32'h7f800001};
    endcase
    case (kind)
      3'd0:    return '0;          // +0
      3'd1:    return sgn;         // -0
      3'd2:    return one;
      3'd3:    return sgn | one;
      3'd4:    return qnan;
      3'd5:    return snan;
      3'd6:    return sgn | snan;
      default: return rnd;
    endcase
  endfunction

  // Every lane gets a special value, half the time b repeats a
  task automatic make_feq_operands(input slice_pkg::fp_format_e fmt,
      output slice_pkg::word_t a, output slice_pkg::word_t b);
    int unsigned      w;
    slice_pkg::word_t lmask, va, vb;
    logic [31:0]      r;
    w     = lane_bits(fmt);
    lmask = (w == 32) ? '1 : (slice_pkg::word_t'(1) << w) - 1;
    a     = $random(seed);
    b     = $random(seed);
    for (int unsigned l = 0; l < 32 / w; l++) begin
      r  = $random(seed);
      va = special_value(fmt, r[2:0], a >> (l * w)) & lmask;
      vb = r[3] ? va : special_value(fmt, r[6:4], b >> (l * w)) & lmask;
      a  = (a & ~(lmask << (l * w))) | (va << (l * w));
      b  = (b & ~(lmask << (l * w))) | (vb << (l * w));
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin : stimulus
    slice_pkg::word_t a, b;
    logic [31:0]      r;
    rst_i = 1'b1;
    flush_i = 1'b0;
    in_valid_i = 1'b0;
    out_ready_i = 1'b1;
    operand_a_i = '0;
    operand_b_i = '0;
    op_i = slice_pkg::SGNJ;
    fmt_i = slice_pkg::FP32;
    vectorial_i = 1'b0;
    tag_i = '0;
    next_tag = '0;
    ready_mode = 2'd0;
    latency_on = 1'b0;
    repeat (8) @(posedge clk_i);
    #DRIVE_DLY;
    rst_i = 1'b0;
    check_bit("out_valid_o", out_valid_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("in_ready_o", in_ready_o, 1'b1);
    latency_on = 1'b1;

    // Scalar sign injection, then vector sign injection in FP16 and FP8
    for (int f = 0; f < 3; f++)
      for (int o = 0; o < 3; o++)
        repeat (2) send_op($random(seed), $random(seed), slice_pkg::operation_e'(o),
                           slice_pkg::fp_format_e'(f), 1'b0);
    for (int f = 1; f < 3; f++)
      for (int o = 0; o < 3; o++)
        repeat (6) send_op($random(seed), $random(seed), slice_pkg::operation_e'(o),
                           slice_pkg::fp_format_e'(f), 1'b1);

    // FEQ with zeros, NaNs and repeated values, scalar and vector
    for (int f = 0; f < 3; f++)
      for (int v = 0; v < 2; v++)
        repeat (6) begin
          make_feq_operands(slice_pkg::fp_format_e'(f), a, b);
          send_op(a, b, slice_pkg::FEQ, slice_pkg::fp_format_e'(f), v[0]);
        end

    // Random back-pressure with idle gaps
    wait_idle();
    latency_on = 1'b0;
    ready_mode = 2'd2;
    repeat (40) begin
      r = $random(seed);
      send_op($random(seed), $random(seed), slice_pkg::operation_e'(r[1:0]),
              slice_pkg::fp_format_e'(r[3:2] % 2'd3), r[4]);
      repeat (r[6:5]) @(posedge clk_i);
      if (r[6:5] != 0) #DRIVE_DLY;
    end

    // Fill the stalled pipe and flush it
    wait_idle();
    ready_mode = 2'd1;
    @(posedge clk_i);
    #DRIVE_DLY;
    repeat (PIPE) send_op($random(seed), $random(seed), slice_pkg::SGNJX, slice_pkg::FP8, 1'b1);
    flush_i = 1'b1;
    @(posedge clk_i);
    #DRIVE_DLY;
    flush_i = 1'b0;
    exp_q.delete();
    acc_q.delete();
    check_bit("out_valid_o", out_valid_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);
    ready_mode = 2'd0;
    @(posedge clk_i);
    #DRIVE_DLY;
    latency_on = 1'b1;
    repeat (6) begin
      r = $random(seed);
      send_op($random(seed), $random(seed), slice_pkg::operation_e'(r[1:0]),
              slice_pkg::fp_format_e'(r[3:2] % 2'd3), r[4]);
    end

    wait_idle();
    if (exp_q.size() != 0 || n_checked != NUM_OPS - PIPE) begin
      $display("Run ended with %0d results checked out of %0d", n_checked, NUM_OPS - PIPE);
      stop_run();
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/slice_pkg.sv
verilog/lane_ops.sv
verilog/slice_pipe.sv
verilog/result_pack.sv
verilog/multifmt_slice.sv
test/tb_multifmt_slice.sv

// ==== Bender.yml ====
package:
  name: multifmt_slice

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/slice_pkg.sv
      - verilog/lane_ops.sv
      - verilog/slice_pipe.sv
      - verilog/result_pack.sv
      - verilog/multifmt_slice.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_multifmt_slice.sv
